//--- verilog.f
design/axm_pkg.sv
design/approx_mult_16.sv
design/axm_pipe.sv
design/err_stats.sv
design/axm_top.sv
sim/axm_props.sv
sim/axm_checker.sv
sim/tb_axm.sv

//--- Bender.yml
package:
  name: axm

sources:
  - design/axm_pkg.sv
  - design/approx_mult_16.sv
  - design/axm_pipe.sv
  - design/err_stats.sv
  - design/axm_top.sv
  - target: simulation
    files:
      - sim/axm_props.sv
      - sim/axm_checker.sv
      - sim/tb_axm.sv

//--- sim/tb_axm.sv
`default_nettype none

module tb_axm;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 8;
    localparam int N_RAND = 300;
    localparam int N_CORNER = 25;
    localparam int N_GAP = 120;
    localparam int MAX_GAP = 3;
    localparam int N_CLR = 10;
    // Longest wait for the pipeline to empty, well above its two-cycle latency
    localparam int DRAIN_MAX = 8;
    // Idle and drain cycles between the tests
    localparam int OVERHEAD = 60;
    localparam int PLANNED = RESET_CYCLES + N_RAND + N_CORNER + N_GAP * (MAX_GAP + 1)
                             + N_CLR + OVERHEAD;
    localparam int TIMEOUT_NS = 2 * PLANNED * CLK_PERIOD;

    logic clk;
    logic rst_n;
    logic in_valid;
    axm_pkg::op_s in_op;
    logic stats_clear;
    logic drain_check;
    logic out_valid;
    axm_pkg::res_s out_res;
    logic [axm_pkg::CNT_W-1:0] stat_count;
    logic [axm_pkg::CNT_W-1:0] stat_err_count;
    logic [axm_pkg::SUM_W-1:0] stat_sum_abs;
    logic [axm_pkg::ERR_W-1:0] stat_max_abs;
    int errors;
    int exact_errs;
    int approx_errs;
    int stat_errs;
    int compared;
    int pending;
    int prop_fails;

    logic [31:0] rng;
    logic [15:0] va;
    logic [15:0] vb;
    logic [15:0] vg;
    int e0;
    int x0;
    int a0;
    axm_pkg::operand_t corners[5] = '{-16'sd32768, 16'sd32767, 16'sd0, -16'sd1, 16'sd1};

    axm_top #(
        .CNT_W (axm_pkg::CNT_W),
        .SUM_W (axm_pkg::SUM_W)
    ) axm_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_op          (in_op),
        .stats_clear    (stats_clear),
        .out_valid      (out_valid),
        .out_res        (out_res),
        .stat_count     (stat_count),
        .stat_err_count (stat_err_count),
        .stat_sum_abs   (stat_sum_abs),
        .stat_max_abs   (stat_max_abs)
    );

    axm_checker #(
        .CNT_W (axm_pkg::CNT_W),
        .SUM_W (axm_pkg::SUM_W)
    ) axm_checker_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic draw(output logic [15:0] v);
        rng = lcg_next(rng);
        v = rng[31:16];
    endtask

    task automatic drive(input logic valid, input logic [15:0] x, input logic [15:0] y,
                         input logic clr);
        @(negedge clk);
        in_valid = valid;
        in_op.x = x;
        in_op.y = y;
        stats_clear = clr;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            drive(1'b0, '0, '0, 1'b0);
        end
    endtask

    // Waits a bounded time for every result to leave, then two more edges for the statistics
    task automatic drain();
        int n;
        idle(1);
        n = 0;
        while (pending != 0 && n < DRAIN_MAX) begin
            @(negedge clk);
            n++;
        end
        idle(2);
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        $display("test %0d %s: %s (%0d errors)", num, name, (errs == 0) ? "pass" : "fail", errs);
    endtask

    initial begin
        rng = 32'd26;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_op = '0;
        stats_clear = 1'b0;
        drain_check = 1'b0;
        prop_fails = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        e0 = errors;
        idle(4);
        report_test(1, "reset state", errors - e0);

        x0 = exact_errs;
        a0 = approx_errs;
        for (int i = 0; i < N_RAND; i++) begin
            draw(va);
            draw(vb);
            drive(1'b1, va, vb, 1'b0);
        end
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                drive(1'b1, corners[i], corners[j], 1'b0);
            end
        end
        drain();
        report_test(2, "exact path", exact_errs - x0);
        report_test(3, "approximate path", approx_errs - a0);

        e0 = errors;
        for (int i = 0; i < N_GAP; i++) begin
            draw(va);
            draw(vb);
            drive(1'b1, va, vb, 1'b0);
            draw(vg);
            idle(vg % (MAX_GAP + 1));
        end
        drain();
        report_test(4, "gapped stream", errors - e0);
        report_test(5, "statistics", stat_errs);

        e0 = errors;
        drive(1'b0, '0, '0, 1'b1);
        idle(3);
        // Clear lands on the edge where the third result is folded in
        for (int i = 0; i < N_CLR; i++) begin
            draw(va);
            draw(vb);
            drive(1'b1, va, vb, i == 4);
        end
        drain();
        report_test(6, "clear", errors - e0);

        drain_check = 1'b1;
        idle(1);
        prop_fails = axm_top_i.axm_pipe_i.axm_props_i.fails;
        $display("summary: 6 tests, %0d results compared, %0d errors, %0d assertion failures",
                 compared, errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/axm_checker.sv
`default_nettype none

module axm_checker #(
    parameter int CNT_W = axm_pkg::CNT_W,
    parameter int SUM_W = axm_pkg::SUM_W
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  axm_pkg::op_s              in_op,
    input  logic                      stats_clear,
    input  logic                      out_valid,
    input  axm_pkg::res_s             out_res,
    input  logic [CNT_W-1:0]          stat_count,
    input  logic [CNT_W-1:0]          stat_err_count,
    input  logic [SUM_W-1:0]          stat_sum_abs,
    input  logic [axm_pkg::ERR_W-1:0] stat_max_abs,
    input  logic                      drain_check,
    output int                        errors,
    output int                        exact_errs,
    output int                        approx_errs,
    output int                        stat_errs,
    output int                        compared,
    output int                        pending
);

    timeunit 1ns;
    timeprecision 1ps;

    axm_pkg::res_s want_q[$];
    int born_q[$];
    int cycle;

    logic [CNT_W-1:0] m_count;
    logic [CNT_W-1:0] m_err_count;
    logic [SUM_W-1:0] m_sum_abs;
    logic [axm_pkg::ERR_W-1:0] m_max_abs;

    // Row r of the partial products uses multiplier bit a[r-1]
    function automatic logic pp_bit(input logic [15:0] a, input logic [15:0] b,
                                    input int r, input int c);
        logic m;
        m = a[r-1];
        if (c == 16) begin
            return (r == 1) || (r == 16);
        end
        if (c == 15) begin
            return (r == 16) ? (b[15] & m) : ~(b[15] & m);
        end
        return (r == 16) ? ~(b[c] & m) : (b[c] & m);
    endfunction

    function automatic logic [31:0] approx_model(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] p [1:16];
        logic [31:0] acc;
        for (int r = 1; r <= 16; r++) begin
            for (int c = 0; c <= 16; c++) begin
                p[r][c] = pp_bit(a, b, r, c);
            end
        end
        acc = '0;
        for (int r = 7; r <= 16; r++) begin
            for (int c = 0; c <= 16; c++) begin
                acc += 32'(p[r][c]) << (r - 1 + c);
            end
        end
        // Rows 1 to 6 only reach the sum through these bits
        acc += 32'(p[3][0]) << 2;
        acc += 32'(p[1][5] & p[2][4]) << 6;
        acc += 32'(p[1][7] ^ p[2][6]) << 7;
        acc += 32'(p[1][8] ^ p[2][7]) << 8;
        acc += 32'(p[3][7] ^ p[4][6]) << 9;
        acc += 32'(p[3][8] & p[4][7]) << 11;
        acc += 32'(p[1][12] ^ p[2][11]) << 12;
        acc += 32'(p[5][9] & p[6][8]) << 14;
        acc += 32'(p[1][15] ^ p[2][14]) << 15;
        acc += 32'(p[1][15] & p[2][14]) << 16;
        acc += 32'(p[2][15]) << 17;
        acc += 32'(p[3][15] & p[4][14]) << 18;
        acc += 32'(p[5][15] ^ p[6][14]) << 19;
        acc += 32'(p[5][15] & p[6][14]) << 20;
        acc += 32'(p[3][6] ^ p[4][5]) << 8;
        acc += 32'(p[5][7] & p[6][6]) << 12;
        acc += 32'(p[5][10] ^ p[6][9]) << 14;
        acc += 32'(p[3][12] & p[4][11]) << 15;
        acc += 32'(p[3][15] ^ p[4][14]) << 17;
        acc += 32'(p[4][15]) << 18;
        acc += 32'(p[6][15]) << 20;
        acc += 32'(p[5][8] ^ p[6][7]) << 12;
        acc += 32'(p[5][11] ^ p[6][10]) << 15;
        acc += 32'(p[5][13] | p[6][12]) << 17;
        acc += 32'(p[5][14] | p[6][13]) << 18;
        acc += 32'(p[5][13] ^ p[6][12]) << 17;
        return acc;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v, output bit bad);
        bad = (exp_v !== act_v);
        if (bad) begin
            $display("MISMATCH %s: expected %0h, got %0h", name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_stats();
        bit b0;
        bit b1;
        bit b2;
        bit b3;
        compare_value("stat_count", 64'(m_count), 64'(stat_count), b0);
        compare_value("stat_err_count", 64'(m_err_count), 64'(stat_err_count), b1);
        compare_value("stat_sum_abs", 64'(m_sum_abs), 64'(stat_sum_abs), b2);
        compare_value("stat_max_abs", 64'(m_max_abs), 64'(stat_max_abs), b3);
        if (b0 || b1 || b2 || b3) begin
            stat_errs++;
        end
    endtask

    initial begin
        errors = 0;
        exact_errs = 0;
        approx_errs = 0;
        stat_errs = 0;
        compared = 0;
        pending = 0;
    end

    always @(posedge clk) begin : monitor
        axm_pkg::res_s want;
        int born;
        logic [axm_pkg::ERR_W-1:0] mag;
        bit bad_x;
        bit bad_a;
        bit bad_e;
        bit late;
        if (!rst_n) begin
            want_q.delete();
            born_q.delete();
            cycle = 0;
            pending = 0;
            m_count = '0;
            m_err_count = '0;
            m_sum_abs = '0;
            m_max_abs = '0;
        end else begin
            cycle++;
            // Statistics seen here must reflect every edge before this one
            check_stats();
            if (out_valid && want_q.size() == 0) begin
                $display("out_valid high at cycle %0d with no result outstanding", cycle);
                errors++;
            end else if (out_valid) begin
                want = want_q.pop_front();
                born = born_q.pop_front();
                compared++;
                late = (cycle != born + 2);
                if (late) begin
                    $display("result of cycle %0d arrived at cycle %0d, two cycles expected",
                             born, cycle);
                    errors++;
                end
                compare_value("out_res.exact", 64'($unsigned(want.exact)),
                              64'($unsigned(out_res.exact)), bad_x);
                compare_value("out_res.approx", 64'($unsigned(want.approx)),
                              64'($unsigned(out_res.approx)), bad_a);
                compare_value("out_res.err", 64'($unsigned(want.err)),
                              64'($unsigned(out_res.err)), bad_e);
                if (bad_x || late) begin
                    exact_errs++;
                end
                if (bad_a || bad_e) begin
                    approx_errs++;
                end
                mag = (want.err < 0) ? $unsigned(-want.err) : $unsigned(want.err);
                m_count = m_count + 1'b1;
                m_err_count = m_err_count + CNT_W'(want.err != 0);
                m_sum_abs = m_sum_abs + SUM_W'(mag);
                if (mag > m_max_abs) begin
                    m_max_abs = mag;
                end
            end
            if (stats_clear) begin
                m_count = '0;
                m_err_count = '0;
                m_sum_abs = '0;
                m_max_abs = '0;
            end
            if (in_valid) begin
                want.exact = in_op.x * in_op.y;
                want.approx = axm_pkg::product_t'(approx_model(in_op.x, in_op.y));
                want.err = axm_pkg::err_t'(want.exact) - axm_pkg::err_t'(want.approx);
                want_q.push_back(want);
                born_q.push_back(cycle);
            end
            pending = want_q.size();
        end
    end

    always @(posedge drain_check) begin
        if (want_q.size() != 0) begin
            $display("%0d results were sent in but never came out", want_q.size());
            errors++;
        end
    end

endmodule

`default_nettype wire

//--- sim/axm_props.sv
`default_nettype none

module axm_props (
    input logic          clk,
    input logic          rst_n,
    input logic          in_valid,
    input logic          out_valid,
    input axm_pkg::res_s out_res
);

    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;

    a_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            fails++;
            $error("out_valid high while rst_n is low");
        end

    // Two register stages between the input strobe and the result strobe
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, 2))
        else begin
            fails++;
            $error("out_valid does not follow in_valid by two cycles");
        end

    a_err_field: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_res.err == axm_pkg::err_t'(out_res.exact)
                                     - axm_pkg::err_t'(out_res.approx))
        else begin
            fails++;
            $error("error field is not exact minus approximate");
        end

endmodule

bind axm_pipe axm_props axm_props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_res   (out_res)
);

`default_nettype wire

//--- design/axm_top.sv
`default_nettype none

module axm_top #(
    parameter int CNT_W = axm_pkg::CNT_W,
    parameter int SUM_W = axm_pkg::SUM_W
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  axm_pkg::op_s              in_op,
    input  logic                      stats_clear,
    output logic                      out_valid,
    output axm_pkg::res_s             out_res,
    output logic [CNT_W-1:0]          stat_count,
    output logic [CNT_W-1:0]          stat_err_count,
    output logic [SUM_W-1:0]          stat_sum_abs,
    output logic [axm_pkg::ERR_W-1:0] stat_max_abs
);

    axm_pipe axm_pipe_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .out_valid (out_valid),
        .out_res   (out_res)
    );

    // Statistics see the same result stream that leaves the block
    err_stats #(
        .CNT_W (CNT_W),
        .SUM_W (SUM_W)
    ) err_stats_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (stats_clear),
        .res_valid (out_valid),
        .res       (out_res),
        .count     (stat_count),
        .err_count (stat_err_count),
        .sum_abs   (stat_sum_abs),
        .max_abs   (stat_max_abs)
    );

endmodule

`default_nettype wire

//--- design/err_stats.sv
`default_nettype none

module err_stats #(
    parameter int CNT_W = axm_pkg::CNT_W,
    parameter int SUM_W = axm_pkg::SUM_W
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clear,
    input  logic                      res_valid,
    input  axm_pkg::res_s             res,
    output logic [CNT_W-1:0]          count,
    output logic [CNT_W-1:0]          err_count,
    output logic [SUM_W-1:0]          sum_abs,
    output logic [axm_pkg::ERR_W-1:0] max_abs
);

    logic [axm_pkg::ERR_W-1:0] abs_err;
    logic err_nz;

    // The error is at most 2**32-1 in magnitude, so the negation cannot overflow
    assign abs_err = res.err[axm_pkg::ERR_W-1] ? axm_pkg::ERR_W'(-res.err)
                                                : axm_pkg::ERR_W'(res.err);
    assign err_nz = (res.err != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            err_count <= '0;
            sum_abs <= '0;
            max_abs <= '0;
        end else if (clear) begin
            // Clear takes priority, a result on the same edge is lost
            count <= '0;
            err_count <= '0;
            sum_abs <= '0;
            max_abs <= '0;
        end else if (res_valid) begin
            count <= count + 1'b1;
            if (err_nz) begin
                err_count <= err_count + 1'b1;
            end
            sum_abs <= sum_abs + SUM_W'(abs_err);
            if (abs_err > max_abs) begin
                max_abs <= abs_err;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/axm_pipe.sv
`default_nettype none

module axm_pipe (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  axm_pkg::op_s   in_op,
    output logic           out_valid,
    output axm_pkg::res_s  out_res
);

    logic s1_valid;
    axm_pkg::op_s s1_op;

    axm_pkg::product_t approx;
    axm_pkg::product_t exact;
    axm_pkg::err_t err;

    // Stage one, operand register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_op <= in_op;
        end
    end

    approx_mult_16 approx_mult_16_i (
        .x (s1_op.x),
        .y (s1_op.y),
        .z (approx)
    );

    // Both operands are signed, so the reference product is a signed multiply
    assign exact = s1_op.x * s1_op.y;
    assign err = axm_pkg::err_t'(exact) - axm_pkg::err_t'(approx);

    // Stage two, result register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            out_res.approx <= approx;
            out_res.exact <= exact;
            out_res.err <= err;
        end
    end

endmodule

`default_nettype wire

//--- design/approx_mult_16.sv
`default_nettype none

module approx_mult_16 (
    input  axm_pkg::operand_t x,
    input  axm_pkg::operand_t y,
    output axm_pkg::product_t z
);

    // Baugh-Wooley rows, numbered 1 to 16 after the multiplier bit x[row-1]
    logic [16:0] pp [1:16];

    // Partial reduction of rows 1 to 6
    logic [20:0] cw [4];

    logic [31:0] sum;

    for (genvar i = 1; i <= 16; i++) begin : g_row
        if (i == 16) begin : g_sign_row
            // The sign row inverts the magnitude bits instead of the sign column
            assign pp[i][14:0] = ~(y[14:0] & {15{x[15]}});
            assign pp[i][15] = y[15] & x[15];
            assign pp[i][16] = 1'b1;
        end else begin : g_mag_row
            assign pp[i][14:0] = y[14:0] & {15{x[i-1]}};
            assign pp[i][15] = ~(y[15] & x[i-1]);
            // Only the first row carries the constant one of the Baugh-Wooley form
            assign pp[i][16] = 1'(i == 1);
        end
    end

    // Fixed correction pattern, most bits of the low rows are simply dropped
    always_comb begin
        cw[0] = '0;
        cw[1] = '0;
        cw[2] = '0;
        cw[3] = '0;

        cw[0][2] = pp[3][0];
        cw[0][6] = pp[1][5] & pp[2][4];
        cw[0][7] = pp[1][7] ^ pp[2][6];
        cw[0][8] = pp[1][8] ^ pp[2][7];
        cw[0][9] = pp[3][7] ^ pp[4][6];
        cw[0][11] = pp[3][8] & pp[4][7];
        cw[0][12] = pp[1][12] ^ pp[2][11];
        cw[0][14] = pp[5][9] & pp[6][8];
        cw[0][15] = pp[1][15] ^ pp[2][14];
        cw[0][16] = pp[1][15] & pp[2][14];
        cw[0][17] = pp[2][15];
        cw[0][18] = pp[3][15] & pp[4][14];
        cw[0][19] = pp[5][15] ^ pp[6][14];
        cw[0][20] = pp[5][15] & pp[6][14];

        cw[1][8] = pp[3][6] ^ pp[4][5];
        cw[1][12] = pp[5][7] & pp[6][6];
        cw[1][14] = pp[5][10] ^ pp[6][9];
        cw[1][15] = pp[3][12] & pp[4][11];
        cw[1][17] = pp[3][15] ^ pp[4][14];
        cw[1][18] = pp[4][15];
        cw[1][20] = pp[6][15];

        cw[2][12] = pp[5][8] ^ pp[6][7];
        cw[2][15] = pp[5][11] ^ pp[6][10];
        cw[2][17] = pp[5][13] | pp[6][12];
        cw[2][18] = pp[5][14] | pp[6][13];

        // A lone sum bit, its carry sits in cw[2][17]
        cw[3][17] = pp[5][13] ^ pp[6][12];
    end

    // Rows 7 to 16 go in at full weight, the sum wraps at 32 bits
    always_comb begin
        sum = 32'(cw[0]) + 32'(cw[1]) + 32'(cw[2]) + 32'(cw[3]);
        for (int k = 7; k <= 16; k++) begin
            sum = sum + (32'(pp[k]) << (k - 1));
        end
    end

    assign z = axm_pkg::product_t'(sum);

endmodule

`default_nettype wire

//--- design/axm_pkg.sv
`default_nettype none

package axm_pkg;

    // Operand and product widths are fixed by the approximation pattern
    localparam int OP_W = 16;
    localparam int PROD_W = 32;

    // One extra bit so that exact minus approximate never overflows
    localparam int ERR_W = 33;

    // Default statistics widths, passed down from the top level
    localparam int CNT_W = 24;
    localparam int SUM_W = 48;

    typedef logic signed [OP_W-1:0] operand_t;
    typedef logic signed [PROD_W-1:0] product_t;
    typedef logic signed [ERR_W-1:0] err_t;

    // Input payload, one operand pair
    typedef struct packed {
        operand_t x;
        operand_t y;
    } op_s;

    // Result payload
    typedef struct packed {
        product_t approx;
        product_t exact;
        err_t err;
    } res_s;

endpackage

`default_nettype wire
